//--- src/simd_regfile_pkg.sv
// shared sizes, opcodes and packed types for the SIMD register file RTL and its testbench
package simd_regfile_pkg;

   // lane count and word size
   localparam int NUM_LANES = 4;
   localparam int WORD_W    = 16;

   // per-lane bank geometry
   localparam int REG_ELS = 16;
   localparam int REG_AW  = 4;

   // result FIFO depth, also the number of issue credits
   localparam int RES_FIFO_DEPTH = 4;

   // credit counter must hold 0..RES_FIFO_DEPTH
   localparam int CREDIT_W = $clog2(RES_FIFO_DEPTH + 1);

   // FIFO pointers wrap naturally, depth is a power of two
   localparam int FIFO_PTR_W = $clog2(RES_FIFO_DEPTH);

   typedef logic [WORD_W-1:0] lane_word_t;
   typedef logic [REG_AW-1:0] reg_addr_t;

   typedef enum logic [2:0]
   {
      OP_LOAD = 3'd0,
      OP_ADD  = 3'd1,
      OP_SUB  = 3'd2,
      OP_AND  = 3'd3,
      OP_XOR  = 3'd4,
      OP_READ = 3'd5
   } opcode_e;

   // host operation, one load word per lane
   typedef struct packed
   {
      opcode_e                           opcode;
      reg_addr_t                         rd;
      reg_addr_t                         rs1;
      reg_addr_t                         rs2;
      lane_word_t [NUM_LANES-1:0]        load_words;
   } op_t;

   // command seen by every lane in lockstep
   typedef struct packed
   {
      opcode_e   opcode;
      reg_addr_t rd;
      reg_addr_t rs1;
      reg_addr_t rs2;
   } lane_cmd_t;

   // result beat, lane 0 in the low bits
   typedef lane_word_t [NUM_LANES-1:0] res_t;

endpackage

//--- src/regbank_2r1w_sync.sv
// one lane's register bank with two synchronous read ports and a write-through write port
`timescale 1ns/1ns

module regbank_2r1w_sync
(
   input  logic                         clk_i,
   input  logic                         reset_i,

   input  logic                         w_v_i,
   input  simd_regfile_pkg::reg_addr_t  w_addr_i,
   input  simd_regfile_pkg::lane_word_t w_data_i,

   input  logic                         r0_v_i,
   input  simd_regfile_pkg::reg_addr_t  r0_addr_i,
   output simd_regfile_pkg::lane_word_t r0_data_o,

   input  logic                         r1_v_i,
   input  simd_regfile_pkg::reg_addr_t  r1_addr_i,
   output simd_regfile_pkg::lane_word_t r1_data_o
);

   simd_regfile_pkg::lane_word_t mem [simd_regfile_pkg::REG_ELS];

   // same-edge write to the read address wins, so the reader sees new data
   function automatic simd_regfile_pkg::lane_word_t read_word
   (
      input simd_regfile_pkg::reg_addr_t addr
   );
      if (w_v_i && (w_addr_i == addr))
      begin
         return w_data_i;
      end
      return mem[addr];
   endfunction

   // no writes land while in reset
   always_ff @(posedge clk_i)
   begin
      if (!reset_i && w_v_i)
      begin
         mem[w_addr_i] <= w_data_i;
      end
   end

   // read ports hold their last value when idle
   always_ff @(posedge clk_i)
   begin
      if (!reset_i && r0_v_i)
      begin
         r0_data_o <= read_word(r0_addr_i);
      end
      if (!reset_i && r1_v_i)
      begin
         r1_data_o <= read_word(r1_addr_i);
      end
   end

endmodule

//--- src/simd_lane.sv
// one SIMD lane: bank read, operand select, ALU and write-back in two stages
`timescale 1ns/1ns

module simd_lane
(
   input  logic                          clk_i,
   input  logic                          reset_i,

   input  logic                          cmd_valid_i,
   input  simd_regfile_pkg::lane_cmd_t   cmd_i,
   input  simd_regfile_pkg::lane_word_t  load_word_i,

   output logic                          res_valid_o,
   output simd_regfile_pkg::lane_word_t  res_word_o
);

   // stage 1 state, valid while bank read data is on the ports
   logic                          s1_valid;
   simd_regfile_pkg::opcode_e     s1_opcode;
   simd_regfile_pkg::reg_addr_t   s1_rd;
   simd_regfile_pkg::lane_word_t  s1_load_word;

   simd_regfile_pkg::lane_word_t  rs1_data;
   simd_regfile_pkg::lane_word_t  rs2_data;
   simd_regfile_pkg::lane_word_t  s2_result;
   logic                          s2_write;

   // sources read in the cmd cycle, rd written at the end of stage 2
   regbank_2r1w_sync u_bank
   (
      .clk_i     (clk_i),
      .reset_i   (reset_i),
      .w_v_i     (s2_write),
      .w_addr_i  (s1_rd),
      .w_data_i  (s2_result),
      .r0_v_i    (cmd_valid_i),
      .r0_addr_i (cmd_i.rs1),
      .r0_data_o (rs1_data),
      .r1_v_i    (cmd_valid_i),
      .r1_addr_i (cmd_i.rs2),
      .r1_data_o (rs2_data)
   );

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         s1_valid <= 1'b0;
      end
      else
      begin
         s1_valid <= cmd_valid_i;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (cmd_valid_i)
      begin
         s1_opcode    <= cmd_i.opcode;
         s1_rd        <= cmd_i.rd;
         s1_load_word <= load_word_i;
      end
   end

   // operand select and ALU, 16-bit wraparound
   always_comb
   begin
      case (s1_opcode)
         simd_regfile_pkg::OP_LOAD: s2_result = s1_load_word;
         simd_regfile_pkg::OP_ADD:  s2_result = rs1_data + rs2_data;
         simd_regfile_pkg::OP_SUB:  s2_result = rs1_data - rs2_data;
         simd_regfile_pkg::OP_AND:  s2_result = rs1_data & rs2_data;
         simd_regfile_pkg::OP_XOR:  s2_result = rs1_data ^ rs2_data;
         default:                   s2_result = rs1_data;
      endcase
   end

   // reads return the source without touching the bank
   assign s2_write = s1_valid && (s1_opcode != simd_regfile_pkg::OP_READ);

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         res_valid_o <= 1'b0;
      end
      else
      begin
         res_valid_o <= s1_valid;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (s1_valid)
      begin
         res_word_o <= s2_result;
      end
   end

endmodule

//--- src/op_issue.sv
// host op intake with output credit tracking and a registered broadcast to the lanes
`timescale 1ns/1ns

module op_issue
(
   input  logic                          clk_i,
   input  logic                          reset_i,

   input  logic                          op_valid_i,
   output logic                          op_ready_o,
   input  simd_regfile_pkg::op_t         op_i,

   input  logic                          credit_return_i,

   output logic                          cmd_valid_o,
   output simd_regfile_pkg::lane_cmd_t   cmd_o,
   output simd_regfile_pkg::lane_word_t [simd_regfile_pkg::NUM_LANES-1:0] load_words_o
);

   // one credit per free result FIFO slot
   logic [simd_regfile_pkg::CREDIT_W-1:0] credits;
   logic                                  accept;

   assign op_ready_o = (credits != '0);
   assign accept     = op_valid_i && op_ready_o;

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         credits <= simd_regfile_pkg::CREDIT_W'(simd_regfile_pkg::RES_FIFO_DEPTH);
      end
      else
      begin
         credits <= credits
                    - simd_regfile_pkg::CREDIT_W'(accept)
                    + simd_regfile_pkg::CREDIT_W'(credit_return_i);
      end
   end

   // single-cycle command pulse
   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         cmd_valid_o <= 1'b0;
      end
      else
      begin
         cmd_valid_o <= accept;
      end
   end

   // split the op into the shared command and the per-lane immediates
   always_ff @(posedge clk_i)
   begin
      if (accept)
      begin
         cmd_o.opcode <= op_i.opcode;
         cmd_o.rd     <= op_i.rd;
         cmd_o.rs1    <= op_i.rs1;
         cmd_o.rs2    <= op_i.rs2;
         load_words_o <= op_i.load_words;
      end
   end

endmodule

//--- src/result_collect.sv
// gathers lane results into one beat and queues beats toward the host
`timescale 1ns/1ns

module result_collect
(
   input  logic                          clk_i,
   input  logic                          reset_i,

   input  logic [simd_regfile_pkg::NUM_LANES-1:0] lane_res_valid_i,
   input  simd_regfile_pkg::lane_word_t [simd_regfile_pkg::NUM_LANES-1:0] lane_res_word_i,

   output logic                          res_valid_o,
   input  logic                          res_ready_i,
   output simd_regfile_pkg::res_t        res_o,

   output logic                          credit_return_o
);

   simd_regfile_pkg::res_t fifo_mem [simd_regfile_pkg::RES_FIFO_DEPTH];

   logic [simd_regfile_pkg::FIFO_PTR_W-1:0] wr_ptr;
   logic [simd_regfile_pkg::FIFO_PTR_W-1:0] rd_ptr;
   logic [simd_regfile_pkg::CREDIT_W-1:0]   count;

   logic push;
   logic pop;

   // lanes run in lockstep, so all valids rise together
   assign push = &lane_res_valid_i;
   assign pop  = res_valid_o && res_ready_i;

   // no full check here, issue credits keep the FIFO from overflowing
   always_ff @(posedge clk_i)
   begin
      if (push)
      begin
         fifo_mem[wr_ptr] <= lane_res_word_i;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (push)
         begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop)
         begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         count <= count
                  + simd_regfile_pkg::CREDIT_W'(push)
                  - simd_regfile_pkg::CREDIT_W'(pop);
      end
   end

   // head of the queue
   assign res_valid_o = (count != '0);
   assign res_o       = fifo_mem[rd_ptr];

   // each accepted beat frees one issue credit
   assign credit_return_o = pop;

endmodule

//--- src/simd_regfile_top.sv
// top of the four-lane SIMD register file, connects issue, lanes and result collection
`timescale 1ns/1ns

module simd_regfile_top
(
   input  logic                    clk_i,
   input  logic                    reset_i,

   input  logic                    op_valid_i,
   output logic                    op_ready_o,
   input  simd_regfile_pkg::op_t   op_i,

   output logic                    res_valid_o,
   input  logic                    res_ready_i,
   output simd_regfile_pkg::res_t  res_o
);

   logic                                   cmd_valid;
   simd_regfile_pkg::lane_cmd_t            cmd;
   simd_regfile_pkg::lane_word_t [simd_regfile_pkg::NUM_LANES-1:0] load_words;

   logic [simd_regfile_pkg::NUM_LANES-1:0] lane_res_valid;
   simd_regfile_pkg::lane_word_t [simd_regfile_pkg::NUM_LANES-1:0] lane_res_word;

   logic                                   credit_return;

   op_issue u_op_issue
   (
      .clk_i           (clk_i),
      .reset_i         (reset_i),
      .op_valid_i      (op_valid_i),
      .op_ready_o      (op_ready_o),
      .op_i            (op_i),
      .credit_return_i (credit_return),
      .cmd_valid_o     (cmd_valid),
      .cmd_o           (cmd),
      .load_words_o    (load_words)
   );

   // lane k takes load word k and drives result word k
   for (genvar k = 0; k < simd_regfile_pkg::NUM_LANES; k++)
   begin : g_lane
      simd_lane u_simd_lane
      (
         .clk_i       (clk_i),
         .reset_i     (reset_i),
         .cmd_valid_i (cmd_valid),
         .cmd_i       (cmd),
         .load_word_i (load_words[k]),
         .res_valid_o (lane_res_valid[k]),
         .res_word_o  (lane_res_word[k])
      );
   end

   result_collect u_result_collect
   (
      .clk_i            (clk_i),
      .reset_i          (reset_i),
      .lane_res_valid_i (lane_res_valid),
      .lane_res_word_i  (lane_res_word),
      .res_valid_o      (res_valid_o),
      .res_ready_i      (res_ready_i),
      .res_o            (res_o),
      .credit_return_o  (credit_return)
   );

endmodule

//--- verif/tb_simd_regfile.sv
// directed testbench for the SIMD register file that runs as the simulation top tb_simd_regfile
`timescale 1ns/1ns

module tb_simd_regfile;

   localparam int NUM_RANDOM_OPS = 300;
   localparam int CHAIN_LEN      = 12;
   localparam int TOTAL_OPS      = 2 * simd_regfile_pkg::REG_ELS + 10 + CHAIN_LEN + 1
                                   + simd_regfile_pkg::RES_FIFO_DEPTH + 1 + NUM_RANDOM_OPS;
   localparam int TIMEOUT_NS     = TOTAL_OPS * 60 + 2000;

   logic                   clk_i;
   logic                   reset_i;
   logic                   op_valid_i;
   logic                   op_ready_o;
   simd_regfile_pkg::op_t  op_i;
   logic                   res_valid_o;
   logic                   res_ready_i;
   simd_regfile_pkg::res_t res_o;

   // 0 ready high, 1 ready low, 2 random
   int ready_mode;

   // reference model state
   simd_regfile_pkg::lane_word_t model_regs [simd_regfile_pkg::NUM_LANES]
                                            [simd_regfile_pkg::REG_ELS];
   simd_regfile_pkg::res_t       exp_q [$];

   simd_regfile_top u_simd_regfile_top
   (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .op_valid_i  (op_valid_i),
      .op_ready_o  (op_ready_o),
      .op_i        (op_i),
      .res_valid_o (res_valid_o),
      .res_ready_i (res_ready_i),
      .res_o       (res_o)
   );

   initial
   begin
      clk_i = 1'b0;
   end

   always #5 clk_i = ~clk_i;

   task automatic check_word(input string name, input int lane,
                             input simd_regfile_pkg::lane_word_t exp_word,
                             input simd_regfile_pkg::lane_word_t act_word);
      assert (act_word === exp_word)
      else
      begin
         $display("[ERROR] t=%0t %s[%0d] expected 0x%h actual 0x%h",
                  $time, name, lane, exp_word, act_word);
         $display("Simulation FAILED");
         $fatal(1, "result mismatch");
      end
   endtask

   task automatic check_bit(input string name, input logic exp_bit, input logic act_bit);
      assert (act_bit === exp_bit)
      else
      begin
         $display("[ERROR] t=%0t %s expected %b actual %b", $time, name, exp_bit, act_bit);
         $display("Simulation FAILED");
         $fatal(1, "control mismatch");
      end
   endtask

   // host side result sink that changes ready on the falling edge
   initial
   begin
      res_ready_i = 1'b0;
      forever
      begin
         @(negedge clk_i);
         case (ready_mode)
            0:       res_ready_i = 1'b1;
            1:       res_ready_i = 1'b0;
            default: res_ready_i = 1'($urandom_range(0, 1));
         endcase
      end
   end

   // compare every accepted beat with the head of the expected queue
   always @(posedge clk_i)
   begin
      simd_regfile_pkg::res_t exp_beat;
      if (!reset_i && res_valid_o && res_ready_i)
      begin
         assert (exp_q.size() != 0)
         else
         begin
            $display("a result beat arrived when no result was expected");
            $display("Simulation FAILED");
            $fatal(1, "unexpected beat");
         end
         exp_beat = exp_q.pop_front();
         for (int lane = 0; lane < simd_regfile_pkg::NUM_LANES; lane++)
         begin
            check_word("res_o", lane, exp_beat[lane], res_o[lane]);
         end
      end
   end

   function automatic simd_regfile_pkg::op_t make_op(input simd_regfile_pkg::opcode_e opc,
                                                     input int rd, input int rs1, input int rs2);
      simd_regfile_pkg::op_t op;
      op.opcode     = opc;
      op.rd         = simd_regfile_pkg::reg_addr_t'(rd);
      op.rs1        = simd_regfile_pkg::reg_addr_t'(rs1);
      op.rs2        = simd_regfile_pkg::reg_addr_t'(rs2);
      op.load_words = '0;
      return op;
   endfunction

   // model one accepted op in every lane
   task automatic record_op(input simd_regfile_pkg::op_t op);
      simd_regfile_pkg::res_t       beat;
      simd_regfile_pkg::lane_word_t a;
      simd_regfile_pkg::lane_word_t b;
      for (int lane = 0; lane < simd_regfile_pkg::NUM_LANES; lane++)
      begin
         a = model_regs[lane][op.rs1];
         b = model_regs[lane][op.rs2];
         case (op.opcode)
            simd_regfile_pkg::OP_LOAD: beat[lane] = op.load_words[lane];
            simd_regfile_pkg::OP_ADD:  beat[lane] = a + b;
            simd_regfile_pkg::OP_SUB:  beat[lane] = a - b;
            simd_regfile_pkg::OP_AND:  beat[lane] = a & b;
            simd_regfile_pkg::OP_XOR:  beat[lane] = a ^ b;
            default:                   beat[lane] = a;
         endcase
         if (op.opcode != simd_regfile_pkg::OP_READ)
         begin
            model_regs[lane][op.rd] = beat[lane];
         end
      end
      exp_q.push_back(beat);
   endtask

   task automatic present_op(input simd_regfile_pkg::op_t op);
      @(negedge clk_i);
      op_valid_i = 1'b1;
      op_i       = op;
   endtask

   // valid stays high on return so the next op can follow on the next cycle
   task automatic send_op(input simd_regfile_pkg::op_t op);
      present_op(op);
      do
      begin
         @(posedge clk_i);
      end
      while (!op_ready_o);
      record_op(op);
   endtask

   task automatic drain();
      @(negedge clk_i);
      op_valid_i = 1'b0;
      while (exp_q.size() != 0)
      begin
         @(posedge clk_i);
      end
   endtask

   task automatic set_ready_mode(input int mode);
      @(posedge clk_i);
      ready_mode = mode;
   endtask

   task automatic test_reset_state();
      check_bit("op_ready_o", 1'b1, op_ready_o);
      check_bit("res_valid_o", 1'b0, res_valid_o);
   endtask

   task automatic test_load_read();
      simd_regfile_pkg::op_t op;
      int                    cycles;
      for (int r = 0; r < simd_regfile_pkg::REG_ELS; r++)
      begin
         op = make_op(simd_regfile_pkg::OP_LOAD, r, 0, 0);
         for (int lane = 0; lane < simd_regfile_pkg::NUM_LANES; lane++)
         begin
            op.load_words[lane] = {4'(lane), 4'(r), 8'($urandom)};
         end
         send_op(op);
         if (r == 0)
         begin
            // first beat into an empty FIFO reaches the head three edges after acceptance
            @(negedge clk_i);
            op_valid_i = 1'b0;
            cycles     = 0;
            while (!res_valid_o && cycles < 20)
            begin
               @(negedge clk_i);
               cycles++;
            end
            assert (cycles == 3)
            else
            begin
               $display("[ERROR] t=%0t res_valid_o latency expected 3 actual %0d",
                        $time, cycles);
               $display("Simulation FAILED");
               $fatal(1, "latency mismatch");
            end
         end
      end
      for (int r = 0; r < simd_regfile_pkg::REG_ELS; r++)
      begin
         send_op(make_op(simd_regfile_pkg::OP_READ, 0, r, 0));
      end
      drain();
   endtask

   task automatic test_alu();
      simd_regfile_pkg::op_t op1;
      simd_regfile_pkg::op_t op2;
      op1 = make_op(simd_regfile_pkg::OP_LOAD, 1, 0, 0);
      op2 = make_op(simd_regfile_pkg::OP_LOAD, 2, 0, 0);
      // operands near the top of the range so add and sub wrap
      for (int lane = 0; lane < simd_regfile_pkg::NUM_LANES; lane++)
      begin
         op1.load_words[lane] = 16'hfff0 + 16'(lane);
         op2.load_words[lane] = 16'h0020 + 16'(lane * 3);
      end
      send_op(op1);
      send_op(op2);
      send_op(make_op(simd_regfile_pkg::OP_ADD, 8, 1, 2));
      send_op(make_op(simd_regfile_pkg::OP_SUB, 9, 2, 1));
      send_op(make_op(simd_regfile_pkg::OP_AND, 10, 1, 2));
      send_op(make_op(simd_regfile_pkg::OP_XOR, 11, 1, 8));
      for (int r = 8; r < 12; r++)
      begin
         send_op(make_op(simd_regfile_pkg::OP_READ, 0, r, 0));
      end
      drain();
   endtask

   task automatic test_dependent_chain();
      simd_regfile_pkg::op_t   op;
      simd_regfile_pkg::opcode_e opc;
      int                      prev;
      int                      rd;
      op = make_op(simd_regfile_pkg::OP_LOAD, 5, 0, 0);
      for (int lane = 0; lane < simd_regfile_pkg::NUM_LANES; lane++)
      begin
         op.load_words[lane] = 16'($urandom);
      end
      send_op(op);
      prev = 5;
      for (int i = 0; i < CHAIN_LEN; i++)
      begin
         opc = simd_regfile_pkg::opcode_e'(3'(1 + (i % 4)));
         rd  = int'($urandom_range(0, 15));
         if (i % 2 == 0)
         begin
            op = make_op(opc, rd, prev, int'($urandom_range(0, 15)));
         end
         else
         begin
            op = make_op(opc, rd, int'($urandom_range(0, 15)), prev);
         end
         send_op(op);
         prev = rd;
      end
      drain();
   endtask

   task automatic test_back_pressure();
      simd_regfile_pkg::op_t op;
      set_ready_mode(1);
      for (int i = 0; i < simd_regfile_pkg::RES_FIFO_DEPTH; i++)
      begin
         present_op(make_op(simd_regfile_pkg::OP_READ, 0, i, 0));
         @(posedge clk_i);
         check_bit("op_ready_o", 1'b1, op_ready_o);
         record_op(op_i);
      end
      op = make_op(simd_regfile_pkg::OP_ADD, 12, 3, 4);
      present_op(op);
      repeat (8)
      begin
         @(posedge clk_i);
         check_bit("op_ready_o", 1'b0, op_ready_o);
      end
      check_bit("res_valid_o", 1'b1, res_valid_o);
      ready_mode = 0;
      do
      begin
         @(posedge clk_i);
      end
      while (!op_ready_o);
      record_op(op);
      drain();
   endtask

   task automatic test_random_mix();
      simd_regfile_pkg::op_t op;
      set_ready_mode(2);
      for (int i = 0; i < NUM_RANDOM_OPS; i++)
      begin
         if ($urandom_range(0, 3) == 0)
         begin
            @(negedge clk_i);
            op_valid_i = 1'b0;
         end
         op = make_op(simd_regfile_pkg::opcode_e'(3'($urandom_range(0, 5))),
                      int'($urandom_range(0, 15)), int'($urandom_range(0, 15)),
                      int'($urandom_range(0, 15)));
         for (int lane = 0; lane < simd_regfile_pkg::NUM_LANES; lane++)
         begin
            op.load_words[lane] = 16'($urandom);
         end
         send_op(op);
      end
      drain();
      set_ready_mode(0);
   endtask

   initial
   begin
      #(TIMEOUT_NS);
      $display("the run timed out after %0d ns without finishing the tests", TIMEOUT_NS);
      $display("Simulation FAILED");
      $fatal(1, "timeout");
   end

   initial
   begin
      void'($urandom(32'he88f));
      reset_i     = 1'b1;
      op_valid_i  = 1'b0;
      op_i        = '0;
      ready_mode  = 0;
      repeat (8) @(posedge clk_i);
      @(negedge clk_i);
      reset_i = 1'b0;

      test_reset_state();
      test_load_read();
      test_alu();
      test_dependent_chain();
      test_back_pressure();
      test_random_mix();

      $display("Simulation PASSED");
      $finish;
   end

endmodule

//--- simd_regfile.f
src/simd_regfile_pkg.sv
src/regbank_2r1w_sync.sv
src/simd_lane.sv
src/op_issue.sv
src/result_collect.sv
src/simd_regfile_top.sv
verif/tb_simd_regfile.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the SIMD register file testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
   --top-module tb_simd_regfile \
   -f simd_regfile.f \
   -o Vtb_simd_regfile
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit 1
fi

sim_out=$(./obj_dir/Vtb_simd_regfile 2>&1)
status=$?
echo "$sim_out"

if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$sim_out" | grep -q "^Simulation PASSED$"; then
   exit 0
fi

echo "pass message not found in simulation output"
exit 1
